//--- rp_settings.svh
////////////////////////////////////////
// width, region, id and reset code macros
////////////////////////////////////////

`ifndef RP_SETTINGS_SVH
`define RP_SETTINGS_SVH

////////////////////////////////////////
// sample widths
////////////////////////////////////////

`define RP_SMP_W          14            // signed sample
`define RP_SUM_W          15            // gen + ctl before clamp
`define RP_RAW_W          16            // raw adc bus with 2 spare lsbs

////////////////////////////////////////
// system bus regions
////////////////////////////////////////

`define RP_NUM_REGIONS    8
`define RP_REG_MSB        22            // top region select bit
`define RP_REG_LSB        20

// housekeeping block
`define RP_HK_ID          32'h7270_0100 // read only id word
`define RP_LED_W          8

// zero sample in negative slope offset code
`define RP_DAC_ZERO_CODE  14'h1fff

`endif

//--- rp_bus_pkg.sv
////////////////////////////////////////
// system bus request and response types
////////////////////////////////////////

package rp_bus_pkg;

  ////////////////////////////////////////
  // request
  ////////////////////////////////////////

  // one access from the bus master
  // wen and ren are single cycle strobes, never both high
  typedef struct packed {
    logic [32-1:0] addr;   // byte address with region in 22:20
    logic [32-1:0] wdata;  // write data
    logic [ 4-1:0] sel;    // byte select
    logic          wen;    // write strobe
    logic          ren;    // read strobe
  } sys_req_t;

  ////////////////////////////////////////
  // response
  ////////////////////////////////////////

  // rdata and err only mean something while ack is high
  typedef struct packed {
    logic [32-1:0] rdata;  // read data
    logic          ack;    // access done
    logic          err;    // unmapped offset
  } sys_rsp_t;

  // request is about 70 bits
  // response is 34 bits

  // empty regions answer in the strobe cycle
  // housekeeping answers one cycle later

  // no wait states and no back-pressure
  // every strobe gets exactly one ack

endpackage

//--- rp_analog_pkg.sv
////////////////////////////////////////
// sample, raw adc and dac code pair types
////////////////////////////////////////

`include "rp_settings.svh"

package rp_analog_pkg;

  ////////////////////////////////////////
  // samples
  ////////////////////////////////////////

  // two's complement sample
  typedef logic signed [`RP_SMP_W-1:0] sample_t;

  // both channels, a in the upper half
  typedef struct packed {
    sample_t a;  // channel a
    sample_t b;  // channel b
  } smp_pair_t;

  ////////////////////////////////////////
  // converter side
  ////////////////////////////////////////

  // raw adc buses as they come off the pins
  // upper 14 bits carry offset code with negative slope
  typedef struct packed {
    logic [`RP_RAW_W-1:0] a;  // adc channel a
    logic [`RP_RAW_W-1:0] b;  // adc channel b
  } adc_raw_pair_t;

  // unsigned dac codes, also negative slope
  // a zero sample gives sign bit clear and all lower bits set
  typedef struct packed {
    logic [`RP_SMP_W-1:0] a;  // dac channel a
    logic [`RP_SMP_W-1:0] b;  // dac channel b
  } dac_code_pair_t;

  // sample pair is 28 bits
  // raw pair is 32 bits
  // code pair is 28 bits

  // both channels leave as one struct
  // no interleaving on a shared dac bus

endpackage

//--- rp_sys_decode.sv
////////////////////////////////////////
// system bus region decoder and response mux
////////////////////////////////////////

`include "rp_settings.svh"

module rp_sys_decode (
  input  logic                 adc_clk,    // system clock
  input  logic                 rst_n_i,    // sync reset, active low
  // bus from master
  input  rp_bus_pkg::sys_req_t sys_req_i,
  output rp_bus_pkg::sys_rsp_t sys_rsp_o,
  // housekeeping slave in region 0
  output rp_bus_pkg::sys_req_t hk_req_o,
  input  rp_bus_pkg::sys_rsp_t hk_rsp_i
);

  localparam int REG_W = `RP_REG_MSB - `RP_REG_LSB + 1;

  logic [REG_W-1:0]           region;     // address bits 22..20
  logic [`RP_NUM_REGIONS-1:0] cs;         // one hot region select
  logic                       stb;        // any strobe this cycle
  logic                       empty_ack;  // immediate ack of regions 1..7
  logic                       hk_pend_q;  // hk answer due this cycle

  ////////////////////////////////////////
  // region select
  ////////////////////////////////////////

  assign region = sys_req_i.addr[`RP_REG_MSB:`RP_REG_LSB];
  assign cs     = `RP_NUM_REGIONS'(1) << region;
  assign stb    = sys_req_i.wen | sys_req_i.ren;

  // strobes only reach the occupied region
  always_comb
  begin
    hk_req_o     = sys_req_i;
    hk_req_o.wen = sys_req_i.wen & cs[0];
    hk_req_o.ren = sys_req_i.ren & cs[0];
  end

  // unoccupied regions ack right away
  assign empty_ack = stb & (|cs[`RP_NUM_REGIONS-1:1]);

  // remember a region 0 access, its ack comes next cycle
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      hk_pend_q <= 1'b0;
    end
    else
    begin
      hk_pend_q <= hk_req_o.wen | hk_req_o.ren;
    end
  end

  ////////////////////////////////////////
  // response merge
  ////////////////////////////////////////

  always_comb
  begin
    sys_rsp_o.ack   = (hk_pend_q & hk_rsp_i.ack) | empty_ack;
    sys_rsp_o.rdata = hk_pend_q ? hk_rsp_i.rdata : '0;  // empty regions read 0
    sys_rsp_o.err   = hk_pend_q & hk_rsp_i.err;         // never err from empty
  end

endmodule

//--- rp_hk_regs.sv
////////////////////////////////////////
// housekeeping registers with id, loop and led
////////////////////////////////////////

`include "rp_settings.svh"

module rp_hk_regs (
  input  logic                 adc_clk,         // system clock
  input  logic                 rst_n_i,         // sync reset, active low
  // gated request from the decoder
  input  rp_bus_pkg::sys_req_t hk_req_i,
  output rp_bus_pkg::sys_rsp_t hk_rsp_o,
  // configuration outputs
  output logic                 digital_loop_o,  // dac fed back into adc path
  output logic [`RP_LED_W-1:0] led_o
);

  // register map, offset bits 7..0 only
  localparam logic [7:0] OFS_ID   = 8'h00;  // read only
  localparam logic [7:0] OFS_LOOP = 8'h04;
  localparam logic [7:0] OFS_LED  = 8'h08;

  logic [7:0]           ofs;
  logic                 stb;      // read or write this cycle
  logic                 hit;      // offset maps to a register
  logic [32-1:0]        rd_mux;
  logic                 loop_q;
  logic [`RP_LED_W-1:0] led_q;
  logic                 ack_q;
  logic                 err_q;
  logic [32-1:0]        rdata_q;

  assign ofs = hk_req_i.addr[7:0];  // region bits ignored
  assign stb = hk_req_i.wen | hk_req_i.ren;

  ////////////////////////////////////////
  // read decode
  ////////////////////////////////////////

  always_comb
  begin
    hit    = 1'b1;
    rd_mux = '0;
    case (ofs)
      OFS_ID:   rd_mux = `RP_HK_ID;
      OFS_LOOP: rd_mux = {31'd0, loop_q};
      OFS_LED:  rd_mux = {{(32-`RP_LED_W){1'b0}}, led_q};
      default:  hit    = 1'b0;  // acks with err
    endcase
  end

  // control regs and handshake
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      loop_q <= 1'b0;
      led_q  <= '0;
      ack_q  <= 1'b0;
      err_q  <= 1'b0;
    end
    else
    begin
      ack_q <= stb;        // one cycle after strobe
      err_q <= stb & ~hit;
      // both fields sit in the low byte
      if (hk_req_i.wen && hk_req_i.sel[0])
      begin
        case (ofs)
          OFS_LOOP: loop_q <= hk_req_i.wdata[0];
          OFS_LED:  led_q  <= hk_req_i.wdata[`RP_LED_W-1:0];
          default:  ;      // id write dropped
        endcase
      end
    end
  end

  // read data, zero unless a mapped read
  always_ff @(posedge adc_clk)
  begin
    rdata_q <= (hk_req_i.ren && hit) ? rd_mux : '0;
  end

  always_comb
  begin
    hk_rsp_o.rdata = rdata_q;
    hk_rsp_o.ack   = ack_q;
    hk_rsp_o.err   = err_q;
  end

  assign digital_loop_o = loop_q;
  assign led_o          = led_q;

endmodule

//--- rp_adc_frontend.sv
////////////////////////////////////////
// adc input regs, code conversion, loop mux
////////////////////////////////////////

`include "rp_settings.svh"

module rp_adc_frontend (
  input  logic                         adc_clk,    // adc clock
  input  logic                         rst_n_i,    // sync reset, active low
  input  rp_analog_pkg::adc_raw_pair_t adc_raw_i,  // raw pins
  input  logic                         loop_i,     // digital loop enable
  input  rp_analog_pkg::smp_pair_t     dac_smp_i,  // saturated dac samples
  output rp_analog_pkg::smp_pair_t     adc_o
);

  logic [`RP_SMP_W-1:0]     raw_a_q;  // upper bits of raw bus a
  logic [`RP_SMP_W-1:0]     raw_b_q;
  rp_analog_pkg::smp_pair_t conv;     // two's complement view

  // negative slope offset code to two's complement
  // keep the msb, flip the rest
  function automatic rp_analog_pkg::sample_t ofs_to_tc(input logic [`RP_SMP_W-1:0] code);
    return {code[`RP_SMP_W-1], ~code[`RP_SMP_W-2:0]};
  endfunction

  ////////////////////////////////////////
  // input registers
  ////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      raw_a_q <= '0;
      raw_b_q <= '0;
    end
    else
    begin
      raw_a_q <= adc_raw_i.a[`RP_RAW_W-1 -: `RP_SMP_W];  // 2 lsbs dropped
      raw_b_q <= adc_raw_i.b[`RP_RAW_W-1 -: `RP_SMP_W];
    end
  end

  always_comb
  begin
    conv.a = ofs_to_tc(raw_a_q);
    conv.b = ofs_to_tc(raw_b_q);
  end

  // loopback bypasses the registers
  assign adc_o = loop_i ? dac_smp_i : conv;

endmodule

//--- rp_dac_backend.sv
////////////////////////////////////////
// dac summation, saturation and code regs
////////////////////////////////////////

`include "rp_settings.svh"

module rp_dac_backend (
  input  logic                          adc_clk,    // system clock
  input  logic                          rst_n_i,    // sync reset, active low
  input  rp_analog_pkg::smp_pair_t      gen_i,      // generator samples
  input  rp_analog_pkg::smp_pair_t      ctl_i,      // controller samples
  output rp_analog_pkg::smp_pair_t      dac_smp_o,  // clamped sum, comb
  output rp_analog_pkg::dac_code_pair_t dac_o       // registered codes
);

  logic signed [`RP_SUM_W-1:0] sum_a;  // one guard bit
  logic signed [`RP_SUM_W-1:0] sum_b;

  // clamp to 14 bits when the top two bits disagree
  function automatic rp_analog_pkg::sample_t clamp(input logic signed [`RP_SUM_W-1:0] sum);
    if (sum[`RP_SUM_W-1] ^ sum[`RP_SUM_W-2])
    begin
      // overflow, take the limit on the side of the sign
      return {sum[`RP_SUM_W-1], {(`RP_SMP_W-1){~sum[`RP_SUM_W-1]}}};
    end
    return sum[`RP_SMP_W-1:0];
  endfunction

  // two's complement to negative slope offset code
  function automatic logic [`RP_SMP_W-1:0] to_code(input rp_analog_pkg::sample_t smp);
    return {smp[`RP_SMP_W-1], ~smp[`RP_SMP_W-2:0]};
  endfunction

  ////////////////////////////////////////
  // summation and saturation
  ////////////////////////////////////////

  assign sum_a = gen_i.a + ctl_i.a;  // sign extended into 15 bits
  assign sum_b = gen_i.b + ctl_i.b;

  always_comb
  begin
    dac_smp_o.a = clamp(sum_a);
    dac_smp_o.b = clamp(sum_b);
  end

  ////////////////////////////////////////
  // output code registers
  ////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      dac_o.a <= `RP_DAC_ZERO_CODE;  // mid scale
      dac_o.b <= `RP_DAC_ZERO_CODE;
    end
    else
    begin
      dac_o.a <= to_code(dac_smp_o.a);
      dac_o.b <= to_code(dac_smp_o.b);
    end
  end

endmodule

//--- red_pitaya_top.sv
////////////////////////////////////////
// top level with bus fabric and analog path
////////////////////////////////////////

`include "rp_settings.svh"

module red_pitaya_top (
  input  logic                          adc_clk,    // single clock domain
  input  logic                          rst_n_i,    // sync reset, active low
  // system bus
  input  rp_bus_pkg::sys_req_t          sys_req_i,
  output rp_bus_pkg::sys_rsp_t          sys_rsp_o,
  // analog
  input  rp_analog_pkg::adc_raw_pair_t  adc_raw_i,  // raw adc pins
  input  rp_analog_pkg::smp_pair_t      gen_i,      // generator samples
  input  rp_analog_pkg::smp_pair_t      ctl_i,      // controller samples
  output rp_analog_pkg::smp_pair_t      adc_o,      // converted adc data
  output rp_analog_pkg::dac_code_pair_t dac_o,      // dac codes, both channels
  output logic [`RP_LED_W-1:0]          led_o
);

  rp_bus_pkg::sys_req_t     hk_req;        // region 0 request
  rp_bus_pkg::sys_rsp_t     hk_rsp;
  logic                     digital_loop;
  rp_analog_pkg::smp_pair_t dac_smp;       // saturated sum

  ////////////////////////////////////////
  // bus fabric
  ////////////////////////////////////////

  rp_sys_decode i_decode (
    .adc_clk   (adc_clk),
    .rst_n_i   (rst_n_i),
    .sys_req_i (sys_req_i),
    .sys_rsp_o (sys_rsp_o),
    .hk_req_o  (hk_req),
    .hk_rsp_i  (hk_rsp)
  );

  rp_hk_regs i_hk (
    .adc_clk        (adc_clk),
    .rst_n_i        (rst_n_i),
    .hk_req_i       (hk_req),
    .hk_rsp_o       (hk_rsp),
    .digital_loop_o (digital_loop),
    .led_o          (led_o)
  );

  ////////////////////////////////////////
  // analog path
  ////////////////////////////////////////

  rp_adc_frontend i_adc (
    .adc_clk   (adc_clk),
    .rst_n_i   (rst_n_i),
    .adc_raw_i (adc_raw_i),
    .loop_i    (digital_loop),
    .dac_smp_i (dac_smp),     // loopback source
    .adc_o     (adc_o)
  );

  rp_dac_backend i_dac (
    .adc_clk   (adc_clk),
    .rst_n_i   (rst_n_i),
    .gen_i     (gen_i),
    .ctl_i     (ctl_i),
    .dac_smp_o (dac_smp),
    .dac_o     (dac_o)
  );

endmodule

//--- tb_clkgen.sv
////////////////////////////////////////
// testbench clock and reset generator
////////////////////////////////////////

module tb_clkgen #(
  parameter int PERIOD     = 20,  // clock period in time units
  parameter int RST_CYCLES = 2    // rising edges with reset low
) (
  output logic adc_clk_o,
  output logic rst_n_o
);

  initial
  begin
    adc_clk_o = 1'b0;
    forever #(PERIOD / 2) adc_clk_o = ~adc_clk_o;
  end

  // release on a falling edge, away from the sampling edge
  initial
  begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge adc_clk_o);
    @(negedge adc_clk_o);
    rst_n_o = 1'b1;
  end

endmodule

//--- tb_red_pitaya_props.sv
////////////////////////////////////////
// bound assertions on bus and dac behavior
////////////////////////////////////////

`include "rp_settings.svh"

module tb_red_pitaya_props #(
  parameter bit BUS_SIDE = 1'b1  // 1 watches the decoder, 0 the dac backend
) (
  input logic                          adc_clk,
  input logic                          rst_n_i,
  input rp_bus_pkg::sys_req_t          req_i,
  input rp_bus_pkg::sys_rsp_t          rsp_i,
  input rp_analog_pkg::dac_code_pair_t code_i
);

  localparam logic [`RP_SMP_W-1:0] ZERO_CODE = `RP_DAC_ZERO_CODE;

  int   fail_cnt = 0;  // read by the testbench at the end
  logic stb;
  logic empty_stb;     // strobe into regions 1..7

  assign stb       = req_i.wen | req_i.ren;
  assign empty_stb = stb & (req_i.addr[`RP_REG_MSB:`RP_REG_LSB] != '0);

  if (BUS_SIDE)
  begin : g_bus
    // no trailing ack unless a fresh strobe
    a_empty_no_late : assert property (@(posedge adc_clk) disable iff (!rst_n_i)
      empty_stb |=> (!rsp_i.ack || stb))
    else
    begin
      fail_cnt++;
      $error("late ack after an empty region strobe");
    end

    a_one_strobe : assert property (@(posedge adc_clk) disable iff (!rst_n_i)
      !(req_i.wen && req_i.ren))
    else
    begin
      fail_cnt++;
      $error("wen and ren high together");
    end
  end
  else
  begin : g_dac
    // sync reset, so codes show zero one edge later
    a_dac_rst_zero : assert property (@(posedge adc_clk)
      !rst_n_i |=> (code_i.a == ZERO_CODE && code_i.b == ZERO_CODE))
    else
    begin
      fail_cnt++;
      $error("dac code not at zero during reset");
    end
  end

endmodule

////////////////////////////////////////
// attach to decoder and dac backend
////////////////////////////////////////

bind rp_sys_decode tb_red_pitaya_props #(.BUS_SIDE(1'b1)) i_bus_props (
  .adc_clk (adc_clk),
  .rst_n_i (rst_n_i),
  .req_i   (sys_req_i),
  .rsp_i   (sys_rsp_o),
  .code_i  ('0)
);

bind rp_dac_backend tb_red_pitaya_props #(.BUS_SIDE(1'b0)) i_dac_props (
  .adc_clk (adc_clk),
  .rst_n_i (rst_n_i),
  .req_i   ('0),
  .rsp_i   ('0),
  .code_i  (dac_o)
);

//--- tb_red_pitaya.sv
////////////////////////////////////////
// testbench top with stimulus, reference
// models, compare process and watchdog
////////////////////////////////////////

`include "rp_settings.svh"

module tb_red_pitaya;

  localparam int          CLK_PERIOD = 20;
  localparam int          SMP_W      = `RP_SMP_W;
  localparam int          RAW_W      = `RP_RAW_W;
  localparam int          SMP_MAX    = (1 << (SMP_W - 1)) - 1;  // 8191
  localparam int          SMP_MIN    = -(1 << (SMP_W - 1));     // -8192
  localparam logic [31:0] HK_BASE    = 32'h4000_0000;           // region 0, bit 30 junk
  localparam int          NUM_TXN    = 200 + 200 + 12 + 40 + 48;
  localparam int          WATCHDOG_T = NUM_TXN * CLK_PERIOD * 4;

  typedef struct packed {
    int                       due;  // posedge index of the check
    rp_analog_pkg::smp_pair_t val;
  } smp_exp_t;

  typedef struct packed {
    int                            due;
    rp_analog_pkg::dac_code_pair_t val;
  } code_exp_t;

  typedef struct packed {
    int                   due;
    rp_bus_pkg::sys_rsp_t val;
  } rsp_exp_t;

  logic                          adc_clk;
  logic                          rst_n;
  rp_bus_pkg::sys_req_t          sys_req;
  rp_bus_pkg::sys_rsp_t          sys_rsp;
  rp_analog_pkg::adc_raw_pair_t  adc_raw;
  rp_analog_pkg::smp_pair_t      gen;
  rp_analog_pkg::smp_pair_t      ctl;
  rp_analog_pkg::smp_pair_t      adc;
  rp_analog_pkg::dac_code_pair_t dac;
  logic [`RP_LED_W-1:0]          led;

  smp_exp_t             smp_q[$];
  code_exp_t            code_q[$];
  rsp_exp_t             rsp_q[$];
  int                   cyc = 0;       // posedges seen
  bit                   chk_on = 1'b0;
  logic                 loop_m = 1'b0; // register model state
  logic [`RP_LED_W-1:0] led_m = '0;
  int                   err_smp = 0;
  int                   err_code = 0;
  int                   err_rsp = 0;
  int                   err_led = 0;
  int                   err_misc = 0;

  tb_clkgen #(.PERIOD(CLK_PERIOD), .RST_CYCLES(2)) i_clkgen (
    .adc_clk_o (adc_clk),
    .rst_n_o   (rst_n)
  );

  red_pitaya_top uut (
    .adc_clk   (adc_clk),
    .rst_n_i   (rst_n),
    .sys_req_i (sys_req),
    .sys_rsp_o (sys_rsp),
    .adc_raw_i (adc_raw),
    .gen_i     (gen),
    .ctl_i     (ctl),
    .adc_o     (adc),
    .dac_o     (dac),
    .led_o     (led)
  );

  ////////////////////////////////////////
  // reference models
  ////////////////////////////////////////

  // negative slope offset code, code 0 is full positive
  function automatic rp_analog_pkg::smp_pair_t ref_adc(input rp_analog_pkg::adc_raw_pair_t raw);
    rp_analog_pkg::smp_pair_t r;
    int                       ca;
    int                       cb;
    ca  = int'(raw.a[RAW_W-1 -: SMP_W]);  // top 14 bits only
    cb  = int'(raw.b[RAW_W-1 -: SMP_W]);
    r.a = rp_analog_pkg::sample_t'(SMP_MAX - ca);
    r.b = rp_analog_pkg::sample_t'(SMP_MAX - cb);
    return r;
  endfunction

  function automatic int sat_sum(input rp_analog_pkg::sample_t g, input rp_analog_pkg::sample_t c);
    int s;
    s = int'(g) + int'(c);
    if (s > SMP_MAX)
      s = SMP_MAX;
    if (s < SMP_MIN)
      s = SMP_MIN;
    return s;
  endfunction

  function automatic rp_analog_pkg::dac_code_pair_t ref_dac(input rp_analog_pkg::smp_pair_t g,
                                                            input rp_analog_pkg::smp_pair_t c);
    rp_analog_pkg::dac_code_pair_t code;
    logic [31:0]                   ta;
    logic [31:0]                   tb;
    ta     = SMP_MAX - sat_sum(g.a, c.a);  // zero sample lands on 0x1fff
    tb     = SMP_MAX - sat_sum(g.b, c.b);
    code.a = ta[SMP_W-1:0];
    code.b = tb[SMP_W-1:0];
    return code;
  endfunction

  // register model, updates loop_m and led_m on writes
  function automatic rp_bus_pkg::sys_rsp_t ref_bus(input rp_bus_pkg::sys_req_t req);
    rp_bus_pkg::sys_rsp_t rsp;
    rsp     = '0;
    rsp.ack = 1'b1;
    if (req.addr[`RP_REG_MSB:`RP_REG_LSB] != '0)
      return rsp;                          // empty region
    case (req.addr[7:0])
      8'h00: if (req.ren) rsp.rdata = `RP_HK_ID;
      8'h04:
      begin
        if (req.ren)
          rsp.rdata = {31'd0, loop_m};
        else if (req.sel[0])
          loop_m = req.wdata[0];
      end
      8'h08:
      begin
        if (req.ren)
          rsp.rdata = {{(32 - `RP_LED_W){1'b0}}, led_m};
        else if (req.sel[0])
          led_m = req.wdata[`RP_LED_W-1:0];
      end
      default: rsp.err = 1'b1;
    endcase
    return rsp;
  endfunction

  function automatic rp_analog_pkg::sample_t rand_smp();
    logic [31:0] r;
    r = $urandom();
    return r[SMP_W-1:0];
  endfunction

  ////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////

  task automatic check_sample(input rp_analog_pkg::smp_pair_t got,
                              input rp_analog_pkg::smp_pair_t exp);
    if (got !== exp)
    begin
      err_smp++;
      $display("[FAIL] %0t adc_o got a=%0d b=%0d, expected a=%0d b=%0d",
               $time, got.a, got.b, exp.a, exp.b);
    end
  endtask

  task automatic check_code(input rp_analog_pkg::dac_code_pair_t got,
                            input rp_analog_pkg::dac_code_pair_t exp);
    if (got !== exp)
    begin
      err_code++;
      $display("[FAIL] %0t dac_o got a=%h b=%h, expected a=%h b=%h",
               $time, got.a, got.b, exp.a, exp.b);
    end
  endtask

  task automatic check_rsp(input rp_bus_pkg::sys_rsp_t got, input rp_bus_pkg::sys_rsp_t exp);
    if (got !== exp)
    begin
      err_rsp++;
      $display("[FAIL] %0t sys_rsp got ack=%b err=%b rdata=%h, expected ack=%b err=%b rdata=%h",
               $time, got.ack, got.err, got.rdata, exp.ack, exp.err, exp.rdata);
    end
  endtask

  task automatic check_led(input logic [`RP_LED_W-1:0] got, input logic [`RP_LED_W-1:0] exp);
    if (got !== exp)
    begin
      err_led++;
      $display("[FAIL] %0t led_o got %h, expected %h", $time, got, exp);
    end
  endtask

  ////////////////////////////////////////
  // expectation queues
  ////////////////////////////////////////

  task automatic expect_smp(input int due, input rp_analog_pkg::smp_pair_t val);
    smp_exp_t e;
    e.due = due;
    e.val = val;
    smp_q.push_back(e);
  endtask

  task automatic expect_code(input int due, input rp_analog_pkg::dac_code_pair_t val);
    code_exp_t e;
    e.due = due;
    e.val = val;
    code_q.push_back(e);
  endtask

  task automatic expect_rsp(input int due, input rp_bus_pkg::sys_rsp_t val);
    rsp_exp_t e;
    e.due = due;
    e.val = val;
    rsp_q.push_back(e);
  endtask

  // bounded wait until every queued result was compared
  task automatic wait_drain();
    int n;
    n = 0;
    while ((smp_q.size() + code_q.size() + rsp_q.size()) != 0 && n < 16)
    begin
      @(negedge adc_clk);
      n++;
    end
    if ((smp_q.size() + code_q.size() + rsp_q.size()) != 0)
    begin
      err_misc++;
      $display("results still pending 16 cycles after the last input at %0t", $time);
      smp_q.delete();
      code_q.delete();
      rsp_q.delete();
    end
  endtask

  // one strobe, region 0 answers a cycle later, others at once
  task automatic bus_access(input logic wr, input logic [31:0] addr, input logic [31:0] wdata);
    rp_bus_pkg::sys_req_t req;
    int                   lat;
    @(negedge adc_clk);
    req       = '0;
    req.addr  = addr;
    req.wdata = wdata;
    req.sel   = 4'hf;
    req.wen   = wr;
    req.ren   = ~wr;
    lat       = (addr[`RP_REG_MSB:`RP_REG_LSB] == '0) ? 2 : 1;
    expect_rsp(cyc + lat, ref_bus(req));
    sys_req = req;
    @(negedge adc_clk);
    sys_req = '0;
    wait_drain();
  endtask

  ////////////////////////////////////////
  // compare process
  ////////////////////////////////////////

  initial
  begin
    smp_exp_t  se;
    code_exp_t ce;
    rsp_exp_t  re;
    forever
    begin
      @(posedge adc_clk);
      cyc = cyc + 1;
      if (chk_on)
      begin
        if (smp_q.size() != 0 && smp_q[0].due == cyc)
        begin
          se = smp_q.pop_front();
          check_sample(adc, se.val);
        end
        if (code_q.size() != 0 && code_q[0].due == cyc)
        begin
          ce = code_q.pop_front();
          check_code(dac, ce.val);
        end
        // bus is idle and all zero unless a response is due
        if (rsp_q.size() != 0 && rsp_q[0].due == cyc)
        begin
          re = rsp_q.pop_front();
          check_rsp(sys_rsp, re.val);
        end
        else
        begin
          check_rsp(sys_rsp, '0);
        end
      end
    end
  end

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  initial
  begin
    rp_analog_pkg::dac_code_pair_t zero_code;
    rp_analog_pkg::smp_pair_t      exp_s;
    logic [31:0]                   r;
    logic [2:0]                    region;
    int                            assert_errs;
    int                            total;
    sys_req = '0;
    adc_raw = '0;
    gen     = '0;
    ctl     = '0;
    void'($urandom(32'h4f25_720c));
    zero_code.a = `RP_DAC_ZERO_CODE;
    zero_code.b = `RP_DAC_ZERO_CODE;
    wait (rst_n === 1'b1);
    @(negedge adc_clk);
    chk_on = 1'b1;

    // reset state
    repeat (3) @(negedge adc_clk);
    check_code(dac, zero_code);
    check_led(led, '0);

    // adc conversion, loop off
    for (int i = 0; i < 200; i++)
    begin
      @(negedge adc_clk);
      adc_raw = $urandom();
      expect_smp(cyc + 2, ref_adc(adc_raw));
    end
    wait_drain();

    // dac sum, first three hit both clamps and a cancelling pair
    for (int i = 0; i < 200; i++)
    begin
      @(negedge adc_clk);
      case (i)
        0:
        begin
          gen = {rp_analog_pkg::sample_t'(SMP_MAX), rp_analog_pkg::sample_t'(SMP_MAX)};
          ctl = gen;
        end
        1:
        begin
          gen = {rp_analog_pkg::sample_t'(SMP_MIN), rp_analog_pkg::sample_t'(SMP_MIN)};
          ctl = gen;
        end
        2:
        begin
          gen = {rp_analog_pkg::sample_t'(SMP_MAX), rp_analog_pkg::sample_t'(SMP_MIN)};
          ctl = {rp_analog_pkg::sample_t'(SMP_MIN), rp_analog_pkg::sample_t'(SMP_MAX)};
        end
        default:
        begin
          gen = {rand_smp(), rand_smp()};
          ctl = {rand_smp(), rand_smp()};
        end
      endcase
      expect_code(cyc + 2, ref_dac(gen, ctl));
    end
    wait_drain();

    // housekeeping registers
    bus_access(1'b0, HK_BASE | 32'h00, '0);          // id
    r = $urandom();
    bus_access(1'b1, HK_BASE | 32'h08, r);           // led write
    check_led(led, led_m);
    bus_access(1'b0, HK_BASE | 32'h08, '0);
    bus_access(1'b1, HK_BASE | 32'h00, 32'hdead_beef);
    bus_access(1'b0, HK_BASE | 32'h00, '0);          // id unchanged
    bus_access(1'b0, HK_BASE | 32'h0c, '0);          // unmapped read, err
    bus_access(1'b1, HK_BASE | 32'h40, r);           // unmapped write, err

    // empty regions 1..7
    for (int i = 0; i < 40; i++)
    begin
      r      = $urandom();
      region = 3'($urandom_range(7, 1));
      bus_access(r[0], {r[31:23], region, r[19:0]}, $urandom());
    end

    // digital loop on, adc follows the clamped sum at once
    bus_access(1'b1, HK_BASE | 32'h04, 32'h1);
    bus_access(1'b0, HK_BASE | 32'h04, '0);
    for (int i = 0; i < 20; i++)
    begin
      @(negedge adc_clk);
      gen     = {rand_smp(), rand_smp()};
      ctl     = {rand_smp(), rand_smp()};
      adc_raw = $urandom();                          // must be ignored
      exp_s.a = rp_analog_pkg::sample_t'(sat_sum(gen.a, ctl.a));
      exp_s.b = rp_analog_pkg::sample_t'(sat_sum(gen.b, ctl.b));
      expect_smp(cyc + 1, exp_s);
    end
    wait_drain();

    // loop off again, converted raw data is back
    bus_access(1'b1, HK_BASE | 32'h04, 32'h0);
    for (int i = 0; i < 20; i++)
    begin
      @(negedge adc_clk);
      adc_raw = $urandom();
      expect_smp(cyc + 2, ref_adc(adc_raw));
    end
    wait_drain();

    assert_errs = uut.i_decode.i_bus_props.fail_cnt + uut.i_dac.i_dac_props.fail_cnt;
    total       = err_smp + err_code + err_rsp + err_led + err_misc + assert_errs;
    $display("errors: sample %0d code %0d bus %0d led %0d other %0d assertion %0d",
             err_smp, err_code, err_rsp, err_led, err_misc, assert_errs);
    if (total == 0)
    begin
      $display("TEST OK");
    end
    else
    begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // watchdog
  initial
  begin
    #(WATCHDOG_T);
    $display("run did not finish within %0d time units, stopped by watchdog", WATCHDOG_T);
    $display("TEST FAILED");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+.
rp_bus_pkg.sv
rp_analog_pkg.sv
rp_sys_decode.sv
rp_hk_regs.sv
rp_adc_frontend.sv
rp_dac_backend.sv
red_pitaya_top.sv
tb_clkgen.sv
tb_red_pitaya_props.sv
tb_red_pitaya.sv
